// ==== hdl/eth_encap_defines.svh ====
// stream widths, header constants, delay length and fifo depths
`ifndef ETH_ENCAP_DEFINES_SVH
`define ETH_ENCAP_DEFINES_SVH

// stream geometry
`define ETH_DATA_W 64
`define ETH_KEEP_W 8

// header constants, host order
`define ETH_FTYPE_IP 16'h0800
`define IP_PROTO_UDP 8'd17

// beat that carries the last key byte
`define KEY_BEAT 4
`define DELAY_BEATS 12 // steer delay line, must cover KEY_BEAT plus class latency

`define HOLD_DEPTH_LOG2 9
`define BYPASS_DEPTH_LOG2 9
`define VERDICT_DEPTH_LOG2 3

`endif

// ==== hdl/eth_encap_pkg.sv ====
// stream beat and lookup key structs, verdict and state enums
`include "eth_encap_defines.svh"

package eth_encap_pkg;

	// one stream beat, 73 bits
	typedef struct packed {
		logic [`ETH_DATA_W-1:0] data;
		logic [`ETH_KEEP_W-1:0] keep;
		logic                   last;
	} axis_beat_t;

	// hash table key, network byte order
	typedef struct packed {
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] dst_port;
		logic [15:0] src_port;
	} lookup_key_t;

	// any code other than drop lets the frame through
	typedef enum logic [3:0] {
		flag_pass = 4'd0,
		flag_drop = 4'd1
	} lookup_flag_e;

	typedef enum logic [1:0] {
		gate_idle,
		gate_release,
		gate_discard
	} gate_state_e;

	typedef enum logic [1:0] {
		merge_idle,
		merge_bypass,
		merge_udp
	} merge_state_e;

endpackage

// ==== hdl/sync_fifo.sv ====
// fall-through synchronous fifo with wrap-bit pointers
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_LOG2 = 4
) (
	input  logic             clk156,
	input  logic             eth_rst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] din,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             full
);

	logic [WIDTH-1:0]    mem [0:(1 << DEPTH_LOG2)-1];
	logic [DEPTH_LOG2:0] wr_ptr;
	logic [DEPTH_LOG2:0] rd_ptr;
	logic                do_wr;
	logic                do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign empty = (wr_ptr == rd_ptr);
	// same slot, opposite lap
	assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
	               (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

	assign dout = mem[rd_ptr[DEPTH_LOG2-1:0]]; // head word, valid while not empty

	always_ff @(posedge clk156) begin
		if (do_wr)
			mem[wr_ptr[DEPTH_LOG2-1:0]] <= din;
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

// ==== hdl/udp_hdr_parser.sv ====
// header parser: beat counter, key capture, lookup request and frame class
`timescale 1ns/100ps
`include "eth_encap_defines.svh"

module udp_hdr_parser (
	input  logic                       clk156,
	input  logic                       eth_rst,
	input  logic                       rx_valid,
	input  eth_encap_pkg::axis_beat_t  rx_beat,
	output logic                       lookup_valid,
	output eth_encap_pkg::lookup_key_t lookup_key,
	output logic                       cls_valid,
	output logic                       cls_udp
);

	logic [9:0]             beat_cnt;
	logic [15:0]            ftype_q;
	logic [7:0]             proto_q;
	logic [`ETH_DATA_W-1:0] d;
	logic                   is_udp;

	assign d = rx_beat.data;
	assign is_udp = (ftype_q == `ETH_FTYPE_IP) && (proto_q == `IP_PROTO_UDP);

	// beat index within the frame
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			beat_cnt <= '0;
		end else if (rx_valid) begin
			if (rx_beat.last)
				beat_cnt <= '0;
			else if (beat_cnt != '1) // saturate so long frames never hit KEY_BEAT again
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// lane n of beat b is frame byte 8*b+n, fields swapped to network order
	always_ff @(posedge clk156) begin
		if (rx_valid) begin
			case (beat_cnt)
				10'd1: ftype_q <= {d[39:32], d[47:40]}; // bytes 12-13
				10'd2: proto_q <= d[63:56];             // byte 23
				10'd3: begin
					lookup_key.src_ip         <= {d[23:16], d[31:24], d[39:32], d[47:40]};
					lookup_key.dst_ip[31:16]  <= {d[55:48], d[63:56]};
				end
				10'd4: begin
					lookup_key.dst_ip[15:0]   <= {d[7:0], d[15:8]};
					lookup_key.src_port       <= {d[23:16], d[31:24]};
					lookup_key.dst_port       <= {d[39:32], d[47:40]};
				end
				default: ;
			endcase
		end
	end

	// one class pulse per frame, key only for udp
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			lookup_valid <= 1'b0;
			cls_valid    <= 1'b0;
			cls_udp      <= 1'b0;
		end else begin
			lookup_valid <= 1'b0;
			cls_valid    <= 1'b0;
			if (rx_valid && beat_cnt == `KEY_BEAT) begin
				lookup_valid <= is_udp;
				cls_valid    <= 1'b1;
				cls_udp      <= is_udp;
			end else if (rx_valid && rx_beat.last && beat_cnt < `KEY_BEAT) begin
				cls_valid <= 1'b1; // short frame, never udp
				cls_udp   <= 1'b0;
			end
		end
	end

endmodule

// ==== hdl/udp_steer.sv ====
// fixed delay line with per-frame routing to hold or bypass path
`timescale 1ns/100ps
`include "eth_encap_defines.svh"

module udp_steer (
	input  logic                      clk156,
	input  logic                      eth_rst,
	input  logic                      rx_valid,
	input  eth_encap_pkg::axis_beat_t rx_beat,
	input  logic                      cls_valid,
	input  logic                      cls_udp,
	output logic                      hold_valid,
	output eth_encap_pkg::axis_beat_t hold_beat,
	output logic                      byp_valid,
	output eth_encap_pkg::axis_beat_t byp_beat
);

	logic [`DELAY_BEATS-1:0]   dly_valid;
	eth_encap_pkg::axis_beat_t dly_beat [`DELAY_BEATS];
	logic                      out_valid;
	eth_encap_pkg::axis_beat_t out_beat;
	logic                      in_frame;
	logic                      route_udp;
	logic                      cur_udp;
	logic                      cls_pop;
	logic                      cls_head;
	logic                      cls_empty;

	always_ff @(posedge clk156) begin
		if (eth_rst)
			dly_valid <= '0;
		else
			dly_valid <= {dly_valid[`DELAY_BEATS-2:0], rx_valid};
	end

	always_ff @(posedge clk156) begin
		dly_beat[0] <= rx_beat;
		for (int i = 1; i < `DELAY_BEATS; i++)
			dly_beat[i] <= dly_beat[i-1];
	end

	assign out_valid = dly_valid[`DELAY_BEATS-1];
	assign out_beat  = dly_beat[`DELAY_BEATS-1];

	// class is popped on the first beat out and held until last
	assign cls_pop = out_valid && !in_frame && !cls_empty;
	assign cur_udp = in_frame ? route_udp : (cls_head && !cls_empty);

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			in_frame  <= 1'b0;
			route_udp <= 1'b0;
		end else if (out_valid) begin
			if (out_beat.last) begin
				in_frame <= 1'b0;
			end else if (!in_frame) begin
				in_frame  <= 1'b1;
				route_udp <= cur_udp;
			end
		end
	end

	sync_fifo #(.WIDTH(1), .DEPTH_LOG2(2)) u_cls_fifo (
		.clk156 (clk156),
		.eth_rst(eth_rst),
		.wr_en  (cls_valid),
		.din    (cls_udp),
		.rd_en  (cls_pop),
		.dout   (cls_head),
		.empty  (cls_empty),
		.full   ()
	);

	assign hold_valid = out_valid && cur_udp;
	assign hold_beat  = out_beat;
	assign byp_valid  = out_valid && !cur_udp;
	assign byp_beat   = out_beat;

endmodule

// ==== hdl/verdict_gate.sv ====
// verdict queue, hold fifo and release/discard fsm
`timescale 1ns/100ps
`include "eth_encap_defines.svh"

module verdict_gate (
	input  logic                       clk156,
	input  logic                       eth_rst,
	input  logic                       hold_valid,
	input  eth_encap_pkg::axis_beat_t  hold_beat,
	input  logic                       result_valid,
	input  eth_encap_pkg::lookup_flag_e result_flag,
	output logic                       rel_valid,
	output eth_encap_pkg::axis_beat_t  rel_beat,
	input  logic                       rel_ready
);

	eth_encap_pkg::gate_state_e state_q;
	eth_encap_pkg::gate_state_e state_d;
	logic [3:0]                 vq_flag;
	logic                       vq_empty;
	logic                       vq_pop;
	eth_encap_pkg::axis_beat_t  hold_head;
	logic                       hq_empty;
	logic                       hq_pop;

	sync_fifo #(.WIDTH(4), .DEPTH_LOG2(`VERDICT_DEPTH_LOG2)) u_verdict_fifo (
		.clk156 (clk156),
		.eth_rst(eth_rst),
		.wr_en  (result_valid),
		.din    (result_flag),
		.rd_en  (vq_pop),
		.dout   (vq_flag),
		.empty  (vq_empty),
		.full   ()
	);

	sync_fifo #(
		.WIDTH     ($bits(eth_encap_pkg::axis_beat_t)),
		.DEPTH_LOG2(`HOLD_DEPTH_LOG2)
	) u_hold_fifo (
		.clk156 (clk156),
		.eth_rst(eth_rst),
		.wr_en  (hold_valid),
		.din    (hold_beat),
		.rd_en  (hq_pop),
		.dout   (hold_head),
		.empty  (hq_empty),
		.full   ()
	);

	always_comb begin
		state_d = state_q;
		vq_pop  = 1'b0;
		hq_pop  = 1'b0;
		case (state_q)
			eth_encap_pkg::gate_idle: begin
				if (!vq_empty && !hq_empty) begin // verdict and frame both here
					vq_pop  = 1'b1;
					state_d = (vq_flag == eth_encap_pkg::flag_drop) ?
					          eth_encap_pkg::gate_discard : eth_encap_pkg::gate_release;
				end
			end
			eth_encap_pkg::gate_release: begin
				hq_pop = rel_valid && rel_ready;
				if (hq_pop && hold_head.last)
					state_d = eth_encap_pkg::gate_idle;
			end
			eth_encap_pkg::gate_discard: begin
				hq_pop = !hq_empty; // flush one beat per cycle
				if (hq_pop && hold_head.last)
					state_d = eth_encap_pkg::gate_idle;
			end
			default: state_d = eth_encap_pkg::gate_idle;
		endcase
	end

	always_ff @(posedge clk156) begin
		if (eth_rst)
			state_q <= eth_encap_pkg::gate_idle;
		else
			state_q <= state_d;
	end

	assign rel_valid = (state_q == eth_encap_pkg::gate_release) && !hq_empty;
	assign rel_beat  = hold_head;

endmodule

// ==== hdl/tx_merge.sv ====
// bypass fifo and frame-level round-robin merge onto tx
`timescale 1ns/100ps
`include "eth_encap_defines.svh"

module tx_merge (
	input  logic                      clk156,
	input  logic                      eth_rst,
	input  logic                      byp_valid,
	input  eth_encap_pkg::axis_beat_t byp_beat,
	input  logic                      rel_valid,
	input  eth_encap_pkg::axis_beat_t rel_beat,
	output logic                      rel_ready,
	output logic                      tx_valid,
	output eth_encap_pkg::axis_beat_t tx_beat,
	input  logic                      tx_ready
);

	eth_encap_pkg::merge_state_e state_q;
	eth_encap_pkg::merge_state_e state_d;
	eth_encap_pkg::axis_beat_t   byp_head;
	logic                        byp_empty;
	logic                        byp_pop;
	logic                        last_udp;

	sync_fifo #(
		.WIDTH     ($bits(eth_encap_pkg::axis_beat_t)),
		.DEPTH_LOG2(`BYPASS_DEPTH_LOG2)
	) u_byp_fifo (
		.clk156 (clk156),
		.eth_rst(eth_rst),
		.wr_en  (byp_valid),
		.din    (byp_beat),
		.rd_en  (byp_pop),
		.dout   (byp_head),
		.empty  (byp_empty),
		.full   ()
	);

	assign byp_pop   = (state_q == eth_encap_pkg::merge_bypass) && !byp_empty && tx_ready;
	assign rel_ready = (state_q == eth_encap_pkg::merge_udp) && tx_ready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			eth_encap_pkg::merge_idle: begin
				if (!byp_empty && rel_valid) // both waiting, alternate
					state_d = last_udp ? eth_encap_pkg::merge_bypass : eth_encap_pkg::merge_udp;
				else if (!byp_empty)
					state_d = eth_encap_pkg::merge_bypass;
				else if (rel_valid)
					state_d = eth_encap_pkg::merge_udp;
			end
			eth_encap_pkg::merge_bypass: begin
				if (byp_pop && byp_head.last)
					state_d = eth_encap_pkg::merge_idle;
			end
			eth_encap_pkg::merge_udp: begin
				if (rel_ready && rel_valid && rel_beat.last)
					state_d = eth_encap_pkg::merge_idle;
			end
			default: state_d = eth_encap_pkg::merge_idle;
		endcase
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			state_q  <= eth_encap_pkg::merge_idle;
			last_udp <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == eth_encap_pkg::merge_idle && state_d == eth_encap_pkg::merge_udp)
				last_udp <= 1'b1;
			else if (state_q == eth_encap_pkg::merge_idle && state_d == eth_encap_pkg::merge_bypass)
				last_udp <= 1'b0;
		end
	end

	// both sources hold their head until popped
	assign tx_valid = ((state_q == eth_encap_pkg::merge_bypass) && !byp_empty) ||
	                  ((state_q == eth_encap_pkg::merge_udp) && rel_valid);
	assign tx_beat  = (state_q == eth_encap_pkg::merge_udp) ? rel_beat : byp_head;

endmodule

// ==== hdl/eth_encap.sv ====
// udp lookup filter top: parser, steer, verdict gate and tx merge
`timescale 1ns/100ps

module eth_encap (
	input  logic                        clk156,
	input  logic                        eth_rst,
	input  logic                        rx_valid,
	input  eth_encap_pkg::axis_beat_t   rx_beat,
	output logic                        lookup_valid,
	output eth_encap_pkg::lookup_key_t  lookup_key,
	input  logic                        result_valid,
	input  eth_encap_pkg::lookup_flag_e result_flag,
	output logic                        tx_valid,
	output eth_encap_pkg::axis_beat_t   tx_beat,
	input  logic                        tx_ready
);

	logic                      cls_valid;
	logic                      cls_udp;
	logic                      hold_valid;
	eth_encap_pkg::axis_beat_t hold_beat;
	logic                      byp_valid;
	eth_encap_pkg::axis_beat_t byp_beat;
	logic                      rel_valid;
	eth_encap_pkg::axis_beat_t rel_beat;
	logic                      rel_ready;

	udp_hdr_parser u_parser (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.rx_valid    (rx_valid),
		.rx_beat     (rx_beat),
		.lookup_valid(lookup_valid),
		.lookup_key  (lookup_key),
		.cls_valid   (cls_valid),
		.cls_udp     (cls_udp)
	);

	udp_steer u_steer (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.rx_valid  (rx_valid),
		.rx_beat   (rx_beat),
		.cls_valid (cls_valid),
		.cls_udp   (cls_udp),
		.hold_valid(hold_valid),
		.hold_beat (hold_beat),
		.byp_valid (byp_valid),
		.byp_beat  (byp_beat)
	);

	verdict_gate u_gate (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.hold_valid  (hold_valid),
		.hold_beat   (hold_beat),
		.result_valid(result_valid),
		.result_flag (result_flag),
		.rel_valid   (rel_valid),
		.rel_beat    (rel_beat),
		.rel_ready   (rel_ready)
	);

	tx_merge u_merge (
		.clk156   (clk156),
		.eth_rst  (eth_rst),
		.byp_valid(byp_valid),
		.byp_beat (byp_beat),
		.rel_valid(rel_valid),
		.rel_beat (rel_beat),
		.rel_ready(rel_ready),
		.tx_valid (tx_valid),
		.tx_beat  (tx_beat),
		.tx_ready (tx_ready)
	);

endmodule

// ==== verif/eth_encap_props.sv ====
// bound assertions for tx hold under back-pressure, reset outputs and fifo overflow
`timescale 1ns/100ps

module eth_encap_props (
	input logic                      clk156,
	input logic                      eth_rst,
	input logic                      tx_valid,
	input logic                      tx_ready,
	input eth_encap_pkg::axis_beat_t tx_beat,
	input logic                      lookup_valid,
	input logic [3:0]                fifo_wr,   // class, verdict, hold, bypass
	input logic [3:0]                fifo_full
);

	int fail_cnt = 0;

	// stalled beat stays put
	a_tx_hold: assert property (@(posedge clk156) disable iff (eth_rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
	else begin
		fail_cnt++;
		$error("tx beat moved while tx_ready was low");
	end

	a_rst_out: assert property (@(posedge clk156) $fell(eth_rst) |-> !tx_valid && !lookup_valid)
	else begin
		fail_cnt++;
		$error("tx_valid or lookup_valid high right after reset");
	end

	a_no_overflow: assert property (@(posedge clk156) disable iff (eth_rst)
		(fifo_wr & fifo_full) == 4'b0000)
	else begin
		fail_cnt++;
		$error("fifo written while full, wr=%b full=%b", fifo_wr, fifo_full);
	end

endmodule

bind eth_encap eth_encap_props u_props (
	.clk156      (clk156),
	.eth_rst     (eth_rst),
	.tx_valid    (tx_valid),
	.tx_ready    (tx_ready),
	.tx_beat     (tx_beat),
	.lookup_valid(lookup_valid),
	.fifo_wr     ({u_steer.u_cls_fifo.wr_en, u_gate.u_verdict_fifo.wr_en,
	               u_gate.u_hold_fifo.wr_en, u_merge.u_byp_fifo.wr_en}),
	.fifo_full   ({u_steer.u_cls_fifo.full, u_gate.u_verdict_fifo.full,
	               u_gate.u_hold_fifo.full, u_merge.u_byp_fifo.full})
);

// ==== verif/tb_eth_encap.sv ====
// testbench with frame stimulus, lookup engine model, tx scoreboards, watchdog and report
`timescale 1ns/100ps
`include "eth_encap_defines.svh"

module tb_eth_encap;

	localparam int FRAMES_PER_TEST = 60;
	localparam int MAX_BEATS = 12;
	localparam int MAX_DLY = 16; // engine answer delay in cycles
	localparam int WDOG_CYCLES =
		2 * FRAMES_PER_TEST * (MAX_BEATS + MAX_DLY + `DELAY_BEATS) * 4;

	logic                        clk156;
	logic                        eth_rst;
	logic                        rx_valid;
	eth_encap_pkg::axis_beat_t   rx_beat;
	logic                        lookup_valid;
	eth_encap_pkg::lookup_key_t  lookup_key;
	logic                        result_valid;
	eth_encap_pkg::lookup_flag_e result_flag;
	logic                        tx_valid;
	eth_encap_pkg::axis_beat_t   tx_beat;
	logic                        tx_ready;

	logic [63:0]                frm [MAX_BEATS];
	eth_encap_pkg::axis_beat_t  exp_udp [$];
	eth_encap_pkg::axis_beat_t  exp_byp [$];
	eth_encap_pkg::axis_beat_t  out_frm [$];
	eth_encap_pkg::lookup_key_t key_q [$];
	int                         seq_q [$];
	int                         res_seq [$];
	int                         res_due [$];
	logic                       key_beat_udp;
	logic                       key_due_q = 1'b0;
	logic                       rand_ready;
	logic                       ready_rand_q = 1'b0;
	int                         cycle = 0;
	int                         seq = 0;
	int                         err_cnt = 0;
	int                         tx_frames = 0;
	int                         sent_byp = 0;
	int                         sent_pass = 0;
	int                         sent_drop = 0;

	eth_encap u_dut (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.rx_valid    (rx_valid),
		.rx_beat     (rx_beat),
		.lookup_valid(lookup_valid),
		.lookup_key  (lookup_key),
		.result_valid(result_valid),
		.result_flag (result_flag),
		.tx_valid    (tx_valid),
		.tx_beat     (tx_beat),
		.tx_ready    (tx_ready)
	);

	initial begin
		clk156 = 1'b0;
		forever #4 clk156 = ~clk156;
	end

	function automatic bit engine_drops(input int s);
		return (s % 3) == 1;
	endfunction

	// big-endian field at a frame byte offset
	// lane n of beat b is byte 8*b+n
	task automatic put_bytes(input int off, input int n, input logic [31:0] val);
		for (int i = 0; i < n; i++)
			frm[(off + i) / 8][((off + i) % 8) * 8 +: 8] = val[8 * (n - 1 - i) +: 8];
	endtask

	// kind 0 udp, 1 other long frame, 2 short frame
	task automatic send_frame(input int kind);
		int                         nb;
		logic [7:0]                 tail_keep;
		bit                         drop;
		eth_encap_pkg::lookup_key_t key;
		eth_encap_pkg::axis_beat_t  b;
		nb = (kind == 2) ? $urandom_range(1, `KEY_BEAT) : $urandom_range(`KEY_BEAT + 1, MAX_BEATS);
		tail_keep = 8'hff >> $urandom_range(0, 7);
		for (int i = 0; i < MAX_BEATS; i++)
			frm[i] = {$urandom, $urandom};
		put_bytes(0, 2, seq); // sequence number
		key = {$urandom, $urandom, $urandom};
		if (kind != 1) begin // short frames carry a udp header too
			put_bytes(12, 2, `ETH_FTYPE_IP);
			put_bytes(23, 1, `IP_PROTO_UDP);
		end
		if (kind == 0) begin
			put_bytes(26, 4, key.src_ip);
			put_bytes(30, 4, key.dst_ip);
			put_bytes(34, 2, key.src_port);
			put_bytes(36, 2, key.dst_port);
			key_q.push_back(key);
			seq_q.push_back(seq);
		end else if (kind == 1) begin
			if ($urandom_range(0, 1)) begin
				put_bytes(12, 2, 16'h0806); // arp with the udp protocol byte
				put_bytes(23, 1, `IP_PROTO_UDP);
			end else begin
				put_bytes(12, 2, `ETH_FTYPE_IP);
				put_bytes(23, 1, 8'd6); // tcp
			end
		end
		drop = (kind == 0) && engine_drops(seq);
		if (kind != 0)
			sent_byp++;
		else if (drop)
			sent_drop++;
		else
			sent_pass++;
		for (int i = 0; i < nb; i++) begin
			b.data = frm[i];
			b.keep = (i == nb - 1) ? tail_keep : 8'hff;
			b.last = (i == nb - 1);
			rx_valid = 1'b1;
			rx_beat = b;
			key_beat_udp = (kind == 0) && (i == `KEY_BEAT);
			if (kind != 0)
				exp_byp.push_back(b);
			else if (!drop)
				exp_udp.push_back(b);
			@(posedge clk156);
			#1;
		end
		rx_valid = 1'b0;
		key_beat_udp = 1'b0;
		seq++;
		repeat ($urandom_range(4, 12)) @(posedge clk156); // gap between frames
		#1;
	endtask

	task automatic check_frame();
		bit                        udp;
		eth_encap_pkg::axis_beat_t exp;
		udp = out_frm.size() > `KEY_BEAT &&
		      {out_frm[1].data[39:32], out_frm[1].data[47:40]} == `ETH_FTYPE_IP &&
		      out_frm[2].data[63:56] == `IP_PROTO_UDP;
		tx_frames++;
		foreach (out_frm[i]) begin
			if ((udp ? exp_udp.size() : exp_byp.size()) == 0) begin
				err_cnt++;
				$display("unexpected %s frame on tx at %0t, nothing left to expect",
				         udp ? "udp" : "bypass", $time);
				break;
			end
			exp = udp ? exp_udp.pop_front() : exp_byp.pop_front();
			assert (out_frm[i] === exp) else begin
				err_cnt++;
				$display("ERROR t=%0t tx_beat (%s) exp=%h got=%h", $time,
				         udp ? "udp" : "bypass", exp, out_frm[i]);
			end
		end
		out_frm.delete();
	endtask

	task automatic run_test(input string name, input bit bp);
		int err0;
		int tx0;
		err0 = err_cnt + u_dut.u_props.fail_cnt;
		tx0 = tx_frames;
		rand_ready = bp;
		for (int n = 0; n < FRAMES_PER_TEST; n++)
			send_frame($urandom_range(0, 2));
		while (exp_udp.size() || exp_byp.size() || key_q.size() || res_seq.size())
			@(posedge clk156);
		repeat (20) @(posedge clk156); // let drops and strays settle
		#1;
		rand_ready = 1'b0;
		$display("test %s done: %0d tx frames, %0d errors", name, tx_frames - tx0,
		         err_cnt + u_dut.u_props.fail_cnt - err0);
	endtask

	// lookup timing and key check, engine request capture
	always @(posedge clk156) begin
		cycle++;
		if (!eth_rst) begin
			assert (lookup_valid === key_due_q) else begin
				err_cnt++;
				$display("ERROR t=%0t lookup_valid exp=%b got=%b", $time, key_due_q, lookup_valid);
			end
			if (lookup_valid && key_q.size() > 0) begin
				assert (lookup_key === key_q[0]) else begin
					err_cnt++;
					$display("ERROR t=%0t lookup_key exp=%h got=%h", $time, key_q[0], lookup_key);
				end
				void'(key_q.pop_front());
				res_seq.push_back(seq_q.pop_front());
				res_due.push_back(cycle + $urandom_range(1, MAX_DLY));
			end
		end
		key_due_q = rx_valid && key_beat_udp; // beat KEY_BEAT taken this edge
	end

	// engine answers in request order
	always @(posedge clk156) begin
		#1;
		result_valid = 1'b0;
		if (res_due.size() > 0 && res_due[0] <= cycle) begin
			result_valid = 1'b1;
			result_flag = engine_drops(res_seq.pop_front()) ?
			              eth_encap_pkg::flag_drop : eth_encap_pkg::flag_pass;
			void'(res_due.pop_front());
		end
	end

	always @(posedge clk156) begin
		ready_rand_q = rand_ready;
		#1;
		tx_ready = ready_rand_q ? ($urandom_range(0, 3) != 0) : 1'b1;
	end

	always @(posedge clk156) begin
		if (!eth_rst && tx_valid && tx_ready) begin
			out_frm.push_back(tx_beat);
			if (tx_beat.last)
				check_frame();
		end
	end

	initial begin
		void'($urandom(97668));
		eth_rst = 1'b1;
		rx_valid = 1'b0;
		rx_beat = '0;
		key_beat_udp = 1'b0;
		rand_ready = 1'b0;
		result_valid = 1'b0;
		result_flag = eth_encap_pkg::flag_pass;
		tx_ready = 1'b1;
		repeat (2) @(posedge clk156);
		#1;
		eth_rst = 1'b0;
		@(posedge clk156);
		#1;
		run_test("steady", 1'b0);
		run_test("backpressure", 1'b1);
		assert (tx_frames == sent_byp + sent_pass) else begin
			err_cnt++;
			$display("ERROR t=%0t tx frame count exp=%0d got=%0d", $time,
			         sent_byp + sent_pass, tx_frames);
		end
		$display("sent %0d bypass, %0d pass, %0d drop; tx %0d frames; errors %0d", sent_byp,
		         sent_pass, sent_drop, tx_frames, err_cnt + u_dut.u_props.fail_cnt);
		if (err_cnt + u_dut.u_props.fail_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk156);
		$display("watchdog expired after %0d cycles with frames still outstanding", WDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/eth_encap_pkg.sv
hdl/sync_fifo.sv
hdl/udp_hdr_parser.sv
hdl/udp_steer.sv
hdl/verdict_gate.sv
hdl/tx_merge.sv
hdl/eth_encap.sv
verif/eth_encap_props.sv
verif/tb_eth_encap.sv
